// File: p4_lite_pkg.sv
`default_nettype none

package p4_lite_pkg;

    // ==============================
    // Datapath sizes
    // ==============================
    localparam int WORD_WID      = 32;
    localparam int NUM_PORTS     = 2;
    localparam int PORT_WID      = 1;
    localparam int CNT_WID       = 16;

    // Buffer geometry
    localparam int BUF_DEPTH     = 32;
    localparam int BUF_PTR_WID   = 5;
    localparam int BUF_CNT_WID   = 6;
    localparam int MAX_PKT_WORDS = 8;

    // Route table
    localparam int ROUTE_ENTRIES = 16;
    localparam int ROUTE_IDX_WID = 4;

    // Header kind bit values
    localparam logic KIND_IPV4   = 1'b0;
    localparam logic KIND_TUNNEL = 1'b1;

    // ==============================
    // Header word, two views
    // ==============================
    typedef union packed {
        struct packed {
            logic        kind;
            logic [6:0]  proto;
            logic [7:0]  ttl;
            logic [15:0] dst_addr;
        } ipv4;
        struct packed {
            logic        kind;
            logic [6:0]  flags;
            logic [7:0]  tunnel_id;
            logic [14:0] reserved;
            logic        inner_port;
        } tunnel;
    } hdr_word_u;

    // ==============================
    // User metadata word
    // ==============================
    // [31] ingress port, [30] kind, [29:26] route index,
    // [25:22] length in words, [21:0] sequence number
    localparam int META_WID      = 32;
    localparam int META_PORT_BIT = 31;
    localparam int META_KIND_BIT = 30;
    localparam int META_RIDX_LSB = 26;
    localparam int META_LEN_LSB  = 22;
    localparam int META_LEN_WID  = 4;
    localparam int META_SEQ_WID  = 22;

    // Buffer entry is {sop, eop, metadata, word}
    localparam int ENTRY_WID     = WORD_WID + 2 + META_WID;
    localparam int ENT_SOP_BIT   = 65;
    localparam int ENT_EOP_BIT   = 64;
    localparam int ENT_META_LSB  = 32;
    localparam int ENT_WORD_LSB  = 0;

endpackage

`default_nettype wire

// File: ingress_parser.sv
`default_nettype none

module ingress_parser (
    input  logic                                                        axil_if,
    input  logic                                                        rst_n,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0]                           in_valid,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0]                           in_sop,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0]                           in_eop,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0][p4_lite_pkg::WORD_WID-1:0] in_data,
    input  logic [p4_lite_pkg::BUF_CNT_WID-1:0]                         free_count,
    output logic                                                        wr_en,
    output logic [p4_lite_pkg::ENTRY_WID-1:0]                           wr_entry,
    output logic [p4_lite_pkg::CNT_WID-1:0]                             drop_count
);
    import p4_lite_pkg::*;

    // Packet lock state
    logic                     locked;
    logic [PORT_WID-1:0]      lock_port;
    logic                     dropping;
    logic [META_SEQ_WID-1:0]  seq_cnt;
    logic [META_LEN_WID-1:0]  pkt_len;
    logic [META_WID-1:0]      pkt_meta;

    // Selected word this cycle
    logic                     sel_valid;
    logic [PORT_WID-1:0]      sel_port;
    logic                     sel_sop;
    logic                     sel_eop;
    logic [WORD_WID-1:0]      sel_data;
    hdr_word_u                hdr;
    logic [ROUTE_IDX_WID-1:0] route_idx;
    logic                     admit;
    logic                     lost_sop;
    logic [META_WID-1:0]      entry_meta;

    // ==============================
    // Port arbitration
    // ==============================
    // Locked port wins; otherwise lowest port with a sop
    always_comb begin
        sel_valid = 1'b0;
        sel_port  = '0;
        if (locked) begin
            sel_port  = lock_port;
            sel_valid = in_valid[lock_port];
        end else begin
            for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                if (in_valid[p] && in_sop[p]) begin
                    sel_valid = 1'b1;
                    sel_port  = PORT_WID'(p);
                end
            end
        end
    end

    // A sop seen on any port that did not win starts a lost packet
    always_comb begin
        lost_sop = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_valid[p] && in_sop[p] && !(sel_valid && sel_port == PORT_WID'(p))) begin
                lost_sop = 1'b1;
            end
        end
    end

    assign sel_sop  = in_sop[sel_port];
    assign sel_eop  = in_eop[sel_port];
    assign sel_data = in_data[sel_port];

    // ==============================
    // Header decode and metadata
    // ==============================
    assign hdr       = sel_data;
    assign route_idx = (hdr.ipv4.kind == KIND_IPV4) ? hdr.ipv4.dst_addr[ROUTE_IDX_WID-1:0]
                                                    : hdr.tunnel.tunnel_id[ROUTE_IDX_WID-1:0];

    // One write may still be in flight and is not yet in free_count
    assign admit = free_count >= (BUF_CNT_WID'(MAX_PKT_WORDS) + BUF_CNT_WID'(wr_en));

    // Length is 0 in the sop entry; later entries carry the running word number
    always_comb begin
        if (sel_sop) begin
            entry_meta = {sel_port, hdr.ipv4.kind, route_idx, META_LEN_WID'(0), seq_cnt};
        end else begin
            entry_meta = pkt_meta;
            entry_meta[META_LEN_LSB +: META_LEN_WID] = pkt_len + 1'b1;
        end
    end

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            locked     <= 1'b0;
            lock_port  <= '0;
            dropping   <= 1'b0;
            seq_cnt    <= '0;
            pkt_len    <= '0;
            wr_en      <= 1'b0;
            drop_count <= '0;
        end else begin
            wr_en <= 1'b0;
            if (sel_valid) begin
                if (sel_sop) begin
                    lock_port <= sel_port;
                    locked    <= !sel_eop;
                    dropping  <= !admit;
                    pkt_len   <= META_LEN_WID'(1);
                    if (admit) begin
                        wr_en   <= 1'b1;
                        seq_cnt <= seq_cnt + 1'b1;
                    end
                end else begin
                    pkt_len <= pkt_len + 1'b1;
                    wr_en   <= !dropping;
                    if (sel_eop) begin
                        locked <= 1'b0;
                    end
                end
            end
            drop_count <= drop_count + CNT_WID'(sel_valid && sel_sop && !admit)
                                     + CNT_WID'(lost_sop);
        end
    end

    // Entry payload
    always_ff @(posedge axil_if) begin
        wr_entry <= {sel_sop, sel_eop, entry_meta, sel_data};
        if (sel_valid && sel_sop) begin
            pkt_meta <= entry_meta;
        end
    end

endmodule

`default_nettype wire

// File: pkt_buffer.sv
`default_nettype none

module pkt_buffer (
    input  logic                                axil_if,
    input  logic                                rst_n,
    input  logic                                wr_en,
    input  logic [p4_lite_pkg::ENTRY_WID-1:0]   wr_entry,
    input  logic                                rd_en,
    output logic [p4_lite_pkg::ENTRY_WID-1:0]   rd_entry,
    output logic                                empty,
    output logic [p4_lite_pkg::BUF_CNT_WID-1:0] free_count
);
    import p4_lite_pkg::*;

    logic [ENTRY_WID-1:0]   mem [BUF_DEPTH];
    logic [BUF_PTR_WID-1:0] wr_ptr;
    logic [BUF_PTR_WID-1:0] rd_ptr;
    logic [BUF_CNT_WID-1:0] count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full       = (count == BUF_CNT_WID'(BUF_DEPTH));
    assign empty      = (count == '0);
    assign free_count = BUF_CNT_WID'(BUF_DEPTH) - count;

    // Writes to a full buffer are lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // ==============================
    // Pointers and occupancy
    // ==============================
    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==============================
    // Storage and read port
    // ==============================
    always_ff @(posedge axil_if) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry;
        end
        // Entry shows up the cycle after rd_en
        if (do_rd) begin
            rd_entry <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: route_table.sv
`default_nettype none

module route_table (
    input  logic                                  axil_if,
    input  logic                                  rst_n,
    input  logic                                  cfg_wr,
    input  logic [p4_lite_pkg::ROUTE_IDX_WID-1:0] cfg_addr,
    input  logic [2:0]                            cfg_data,
    input  logic [p4_lite_pkg::ROUTE_IDX_WID-1:0] lookup_idx,
    output logic [2:0]                            lookup_entry
);
    import p4_lite_pkg::*;

    // Entry bit 0 egress port, bit 1 drop, bit 2 keep TTL
    logic [2:0] table_q [ROUTE_ENTRIES];

    // ==============================
    // Management writes
    // ==============================
    // All zero after reset: port 0, forward, decrement TTL
    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            for (int i = 0; i < ROUTE_ENTRIES; i++) begin
                table_q[i] <= '0;
            end
        end else if (cfg_wr) begin
            table_q[cfg_addr] <= cfg_data;
        end
    end

    // Lookup is combinational so egress decides in the sop cycle
    assign lookup_entry = table_q[lookup_idx];

endmodule

`default_nettype wire

// File: egress_action.sv
`default_nettype none

module egress_action (
    input  logic                                  axil_if,
    input  logic                                  rst_n,
    input  logic [p4_lite_pkg::ENTRY_WID-1:0]     rd_entry,
    input  logic                                  empty,
    output logic                                  rd_en,
    output logic [p4_lite_pkg::ROUTE_IDX_WID-1:0] lookup_idx,
    input  logic [2:0]                            lookup_entry,
    output logic                                  out_valid,
    output logic [p4_lite_pkg::PORT_WID-1:0]      out_port,
    output logic                                  out_sop,
    output logic                                  out_eop,
    output logic [p4_lite_pkg::WORD_WID-1:0]      out_data,
    output logic [p4_lite_pkg::CNT_WID-1:0]       route_drop_count
);
    import p4_lite_pkg::*;

    // Route entry bits
    localparam int RT_PORT_BIT  = 0;
    localparam int RT_DROP_BIT  = 1;
    localparam int RT_NODEC_BIT = 2;

    // Popped entry fields
    logic                rd_valid;
    logic                ent_sop;
    logic                ent_eop;
    logic [META_WID-1:0] ent_meta;
    logic [WORD_WID-1:0] ent_word;
    logic                sop_in;
    logic                data_in;

    // Header rewrite
    hdr_word_u           hdr_in;
    hdr_word_u           hdr_new;
    logic                ttl_zero;
    logic                drop_now;

    // Per-packet state
    logic                pkt_drop;
    logic [PORT_WID-1:0] pkt_port;
    logic                hdr_pend;
    logic                hdr_eop;
    logic [WORD_WID-1:0] hdr_hold;

    assign ent_sop  = rd_entry[ENT_SOP_BIT];
    assign ent_eop  = rd_entry[ENT_EOP_BIT];
    assign ent_meta = rd_entry[ENT_META_LSB +: META_WID];
    assign ent_word = rd_entry[ENT_WORD_LSB +: WORD_WID];

    assign sop_in  = rd_valid && ent_sop;
    assign data_in = rd_valid && !ent_sop && !pkt_drop;

    // ==============================
    // Buffer drain
    // ==============================
    // No pop while a sop entry is here; that slot carries the header out
    assign rd_en      = !empty && !sop_in;
    assign lookup_idx = ent_meta[META_RIDX_LSB +: ROUTE_IDX_WID];

    // ==============================
    // Route decision and TTL
    // ==============================
    always_comb begin
        hdr_in   = ent_word;
        hdr_new  = hdr_in;
        ttl_zero = (hdr_in.ipv4.kind == KIND_IPV4) && (hdr_in.ipv4.ttl == '0);
        if (hdr_in.ipv4.kind == KIND_IPV4 && !lookup_entry[RT_NODEC_BIT] && !ttl_zero) begin
            hdr_new.ipv4.ttl = hdr_in.ipv4.ttl - 8'd1;
        end
        // Expired ipv4 packets go the same way as table drops
        drop_now = lookup_entry[RT_DROP_BIT] || ttl_zero;
    end

    always_ff @(posedge axil_if) begin
        if (!rst_n) begin
            rd_valid         <= 1'b0;
            pkt_drop         <= 1'b0;
            pkt_port         <= '0;
            hdr_pend         <= 1'b0;
            hdr_eop          <= 1'b0;
            out_valid        <= 1'b0;
            out_port         <= '0;
            out_sop          <= 1'b0;
            out_eop          <= 1'b0;
            route_drop_count <= '0;
        end else begin
            rd_valid  <= rd_en;
            hdr_pend  <= 1'b0;
            out_valid <= 1'b0;
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
            if (sop_in) begin
                // Port decision held until eop
                pkt_drop <= drop_now;
                pkt_port <= lookup_entry[RT_PORT_BIT];
                if (drop_now) begin
                    route_drop_count <= route_drop_count + 1'b1;
                end else begin
                    out_valid <= 1'b1;
                    out_sop   <= 1'b1;
                    out_port  <= lookup_entry[RT_PORT_BIT];
                    hdr_pend  <= 1'b1;
                    hdr_eop   <= ent_eop;
                end
            end else if (hdr_pend) begin
                out_valid <= 1'b1;
                out_eop   <= hdr_eop;
                out_port  <= pkt_port;
            end else if (data_in) begin
                out_valid <= 1'b1;
                out_eop   <= ent_eop;
                out_port  <= pkt_port;
            end
        end
    end

    // Output word: metadata, then held header, then payload
    always_ff @(posedge axil_if) begin
        if (sop_in) begin
            out_data <= ent_meta;
            hdr_hold <= hdr_new;
        end else if (hdr_pend) begin
            out_data <= hdr_hold;
        end else if (data_in) begin
            out_data <= ent_word;
        end
    end

endmodule

`default_nettype wire

// File: p4_lite_top.sv
`default_nettype none

module p4_lite_top (
    input  logic                                                        axil_if,
    input  logic                                                        rst_n,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0]                           in_valid,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0]                           in_sop,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0]                           in_eop,
    input  logic [p4_lite_pkg::NUM_PORTS-1:0][p4_lite_pkg::WORD_WID-1:0] in_data,
    input  logic                                                        cfg_wr,
    input  logic [p4_lite_pkg::ROUTE_IDX_WID-1:0]                       cfg_addr,
    input  logic [2:0]                                                  cfg_data,
    output logic                                                        out_valid,
    output logic [p4_lite_pkg::PORT_WID-1:0]                            out_port,
    output logic                                                        out_sop,
    output logic                                                        out_eop,
    output logic [p4_lite_pkg::WORD_WID-1:0]                            out_data,
    output logic [p4_lite_pkg::CNT_WID-1:0]                             drop_count,
    output logic [p4_lite_pkg::CNT_WID-1:0]                             route_drop_count
);
    import p4_lite_pkg::*;

    // Parser to buffer
    logic                     wr_en;
    logic [ENTRY_WID-1:0]     wr_entry;
    logic [BUF_CNT_WID-1:0]   free_count;

    // Buffer to egress
    logic                     rd_en;
    logic [ENTRY_WID-1:0]     rd_entry;
    logic                     empty;

    // Egress to route table
    logic [ROUTE_IDX_WID-1:0] lookup_idx;
    logic [2:0]               lookup_entry;

    ingress_parser u_ingress_parser (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sop     (in_sop),
        .in_eop     (in_eop),
        .in_data    (in_data),
        .free_count (free_count),
        .wr_en      (wr_en),
        .wr_entry   (wr_entry),
        .drop_count (drop_count)
    );

    pkt_buffer u_pkt_buffer (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_entry   (wr_entry),
        .rd_en      (rd_en),
        .rd_entry   (rd_entry),
        .empty      (empty),
        .free_count (free_count)
    );

    route_table u_route_table (
        .axil_if      (axil_if),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .lookup_idx   (lookup_idx),
        .lookup_entry (lookup_entry)
    );

    egress_action u_egress_action (
        .axil_if          (axil_if),
        .rst_n            (rst_n),
        .rd_entry         (rd_entry),
        .empty            (empty),
        .rd_en            (rd_en),
        .lookup_idx       (lookup_idx),
        .lookup_entry     (lookup_entry),
        .out_valid        (out_valid),
        .out_port         (out_port),
        .out_sop          (out_sop),
        .out_eop          (out_eop),
        .out_data         (out_data),
        .route_drop_count (route_drop_count)
    );

endmodule

`default_nettype wire

// File: p4_lite_chk.sv
`default_nettype none

module p4_lite_chk (
    input  logic axil_if,
    input  logic rst_n,
    input  logic wr_en,
    input  logic full,
    input  logic rd_en,
    input  logic empty,
    input  logic out_valid,
    input  logic out_sop
);
    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Buffer invariants
    // ==============================
    // The parser admission check keeps the FIFO from overflowing
    no_write_when_full: assert property (
        @(posedge axil_if) disable iff (!rst_n)
        wr_en |-> !full
    ) else $error("buffer written while full");

    no_read_when_empty: assert property (
        @(posedge axil_if) disable iff (!rst_n)
        rd_en |-> !empty
    ) else $error("buffer read while empty");

    // ==============================
    // Egress framing
    // ==============================
    // Metadata word is always followed by the header word
    sop_then_data: assert property (
        @(posedge axil_if) disable iff (!rst_n)
        (out_valid && out_sop) |=> (out_valid && !out_sop)
    ) else $error("metadata word not followed by a non-sop word");

endmodule

`default_nettype wire

// File: tb.sv
`default_nettype none

module tb;
    timeunit 1ns;
    timeprecision 1ps;
    import p4_lite_pkg::*;

    logic                                   axil_if;
    logic                                   rst_n;
    logic [NUM_PORTS-1:0]                   in_valid;
    logic [NUM_PORTS-1:0]                   in_sop;
    logic [NUM_PORTS-1:0]                   in_eop;
    logic [NUM_PORTS-1:0][WORD_WID-1:0]     in_data;
    logic                                   cfg_wr;
    logic [ROUTE_IDX_WID-1:0]               cfg_addr;
    logic [2:0]                             cfg_data;
    logic                                   out_valid;
    logic [PORT_WID-1:0]                    out_port;
    logic                                   out_sop;
    logic                                   out_eop;
    logic [WORD_WID-1:0]                    out_data;
    logic [CNT_WID-1:0]                     drop_count;
    logic [CNT_WID-1:0]                     route_drop_count;

    // Reference model state
    logic [2:0]          route_copy [ROUTE_ENTRIES];
    logic [WORD_WID-1:0] exp_data [$];
    logic [PORT_WID-1:0] exp_port [$];
    logic                exp_sop [$];
    logic                exp_eop [$];
    int                  seq_num;
    int                  exp_pkts;
    int                  exp_route_drops;
    int                  rx_pkts;
    int                  gen_words;
    int                  cycle_cnt;
    int                  value_errors;
    int                  other_errors;
    int                  seed_val;
    int                  n;

    p4_lite_top u_p4_lite_top (
        .axil_if          (axil_if),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_sop           (in_sop),
        .in_eop           (in_eop),
        .in_data          (in_data),
        .cfg_wr           (cfg_wr),
        .cfg_addr         (cfg_addr),
        .cfg_data         (cfg_data),
        .out_valid        (out_valid),
        .out_port         (out_port),
        .out_sop          (out_sop),
        .out_eop          (out_eop),
        .out_data         (out_data),
        .drop_count       (drop_count),
        .route_drop_count (route_drop_count)
    );

    bind pkt_buffer p4_lite_chk u_buf_chk (
        .axil_if   (axil_if),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .full      (full),
        .rd_en     (rd_en),
        .empty     (empty),
        .out_valid (1'b0),
        .out_sop   (1'b0)
    );

    bind egress_action p4_lite_chk u_egr_chk (
        .axil_if   (axil_if),
        .rst_n     (rst_n),
        .wr_en     (1'b0),
        .full      (1'b0),
        .rd_en     (rd_en),
        .empty     (empty),
        .out_valid (out_valid),
        .out_sop   (out_sop)
    );

    initial begin
        axil_if = 1'b0;
    end

    always #2 axil_if = ~axil_if;

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_word(input string name, input logic [WORD_WID-1:0] exp,
                              input logic [WORD_WID-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_port(input string name, input logic [PORT_WID-1:0] exp,
                              input logic [PORT_WID-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_WID-1:0] exp,
                               input logic [CNT_WID-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // ==============================
    // Stimulus and model
    // ==============================
    task automatic write_route(input logic [ROUTE_IDX_WID-1:0] addr, input logic [2:0] data);
        @(posedge axil_if);
        cfg_wr   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
        route_copy[addr] = data;
        @(posedge axil_if);
        cfg_wr   <= 1'b0;
    endtask

    task automatic send_packet(input logic [PORT_WID-1:0] port, input logic kind,
                               input logic ttl_zero);
        logic [WORD_WID-1:0]      words [$];
        logic [WORD_WID-1:0]      hdr_out;
        logic [ROUTE_IDX_WID-1:0] ridx;
        logic [7:0]               ttl;
        logic [2:0]               rt;
        logic                     drop;
        int                       len;
        int                       i;
        len = int'($urandom_range(MAX_PKT_WORDS, 1));
        ttl = 8'd1;
        if (kind == KIND_IPV4) begin
            ttl = ttl_zero ? 8'd0 : 8'($urandom_range(255, 1));
            // kind, proto, ttl, dst_addr; route index from dst_addr
            words.push_back({1'b0, 7'($urandom), ttl, 16'($urandom)});
            ridx = words[0][3:0];
        end else begin
            // Tunnel view takes its route index from tunnel_id
            words.push_back({1'b1, 31'($urandom)});
            ridx = words[0][19:16];
        end
        for (i = 1; i < len; i++) begin
            words.push_back($urandom);
        end
        rt   = route_copy[ridx];
        drop = rt[1] || (kind == KIND_IPV4 && ttl == 8'd0);
        hdr_out = words[0];
        if (kind == KIND_IPV4 && !rt[2]) begin
            hdr_out[23:16] = ttl - 8'd1;
        end
        if (drop) begin
            exp_route_drops++;
        end else begin
            exp_pkts++;
            exp_data.push_back({port, kind, ridx, 4'd0, 22'(seq_num)});
            exp_port.push_back(rt[0]);
            exp_sop.push_back(1'b1);
            exp_eop.push_back(1'b0);
            exp_data.push_back(hdr_out);
            exp_port.push_back(rt[0]);
            exp_sop.push_back(1'b0);
            exp_eop.push_back(len == 1);
            for (i = 1; i < len; i++) begin
                exp_data.push_back(words[i]);
                exp_port.push_back(rt[0]);
                exp_sop.push_back(1'b0);
                exp_eop.push_back(i == len - 1);
            end
        end
        seq_num++;
        gen_words += len;
        for (i = 0; i < len; i++) begin
            @(posedge axil_if);
            in_valid       <= '0;
            in_sop         <= '0;
            in_eop         <= '0;
            in_valid[port] <= 1'b1;
            in_sop[port]   <= (i == 0);
            in_eop[port]   <= (i == len - 1);
            in_data[port]  <= words[i];
        end
        @(posedge axil_if);
        in_valid <= '0;
        in_sop   <= '0;
        in_eop   <= '0;
        // At least two idle cycles between packets
        repeat ($urandom_range(4, 1)) @(posedge axil_if);
    endtask

    task automatic wait_drain();
        while (rx_pkts != exp_pkts || route_drop_count < CNT_WID'(exp_route_drops)) begin
            @(negedge axil_if);
        end
    endtask

    // Output monitor samples away from the active edge
    always @(negedge axil_if) begin
        if (rst_n && out_valid) begin
            if (exp_data.size() == 0) begin
                other_errors++;
                $display("unexpected output word %h at %0t ns with nothing expected",
                         out_data, $time);
            end else begin
                check_word("out_data", exp_data.pop_front(), out_data);
                check_port("out_port", exp_port.pop_front(), out_port);
                check_flag("out_sop", exp_sop.pop_front(), out_sop);
                check_flag("out_eop", exp_eop.pop_front(), out_eop);
            end
            if (out_eop) begin
                rx_pkts++;
            end
        end
    end

    // Run limit grows with the generated traffic
    always @(posedge axil_if) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > 40 * gen_words + 1000) begin
            $display("timeout: run did not finish within %0d cycles", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        seed_val        = $urandom(13889);
        route_copy      = '{default: 3'b000};
        seq_num         = 0;
        exp_pkts        = 0;
        exp_route_drops = 0;
        rx_pkts         = 0;
        gen_words       = 0;
        cycle_cnt       = 0;
        value_errors    = 0;
        other_errors    = 0;
        rst_n           = 1'b0;
        in_valid        = '0;
        in_sop          = '0;
        in_eop          = '0;
        in_data         = '0;
        cfg_wr          = 1'b0;
        cfg_addr        = '0;
        cfg_data        = '0;
        repeat (4) @(posedge axil_if);
        rst_n <= 1'b1;
        repeat (2) @(posedge axil_if);

        // Reset table, ipv4 only, everything to port 0
        for (n = 0; n < 24; n++) begin
            send_packet(PORT_WID'($urandom_range(1, 0)), KIND_IPV4, 1'b0);
        end
        wait_drain();

        // Random table, then a port 1 keep-TTL entry and a drop entry
        for (n = 0; n < ROUTE_ENTRIES; n++) begin
            write_route(ROUTE_IDX_WID'(n), 3'($urandom));
        end
        write_route(4'd5, 3'b101);
        write_route(4'd6, 3'b010);

        // Mixed kinds, some expired ipv4 headers
        for (n = 0; n < 48; n++) begin
            send_packet(PORT_WID'($urandom_range(1, 0)), 1'($urandom_range(1, 0)),
                        $urandom_range(7, 0) == 0);
        end
        wait_drain();
        repeat (20) @(posedge axil_if);

        check_count("route_drop_count", CNT_WID'(exp_route_drops), route_drop_count);
        check_count("drop_count", '0, drop_count);
        if (exp_data.size() != 0) begin
            other_errors++;
            $display("%0d expected output words never left the DUT", exp_data.size());
        end
        $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
p4_lite_pkg.sv
ingress_parser.sv
pkt_buffer.sv
route_table.sv
egress_action.sv
p4_lite_top.sv
p4_lite_chk.sv
tb.sv

// File: run.sh
#!/bin/sh
# Build and run the p4_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb -f src.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1
grep -qx "Verification passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
